// ==== vlog.f ====
+incdir+tests
design/leaf_pkg.sv
design/leaf_rx_decode.sv
design/leaf_in_fifo.sv
design/leaf_route_table.sv
design/leaf_tx_arbiter.sv
design/leaf_tx_packer.sv
design/leaf_node.sv
tests/leaf_node_tb.sv

// ==== tests/leaf_node_checks.svh ====
`ifndef LEAF_NODE_CHECKS_SVH
`define LEAF_NODE_CHECKS_SVH

// Reference model
leaf_pkg::route_entry_t route_model [N_OUT];
logic [WORD_BITS-1:0]   exp_rx [N_IN][$];    // Words owed to each user in-port
leaf_pkg::bft_packet_t  exp_tx [N_OUT][$];   // Packets owed on dout, by source port

// Config payload [8:4] is the leaf, [3:0] the port, addr above 5 ignored
task automatic apply_config(input logic [leaf_pkg::ADDR_BITS-1:0] addr,
                            input logic [WORD_BITS-1:0] word);
    int idx;
    idx = int'(addr);
    if (idx < N_OUT) begin
        route_model[idx].leaf = word[8:4];
        route_model[idx].port = word[3:0];
    end
endtask

function automatic leaf_pkg::bft_packet_t expected_packet(input int src,
                                                          input logic [WORD_BITS-1:0] word);
    leaf_pkg::bft_packet_t pkt;
    pkt.vld     = 1'b1;
    pkt.leaf    = route_model[src].leaf;
    pkt.port    = route_model[src].port;
    pkt.addr    = leaf_pkg::ADDR_BITS'(src);   // Source port index
    pkt.payload = word;
    return pkt;
endfunction

task automatic check_word(input string name, input logic [WORD_BITS-1:0] expected,
                          input logic [WORD_BITS-1:0] actual);
    if (actual !== expected) begin
        $display("ERR %s expected %h actual %h", name, expected, actual);
        abort_run();
    end
endtask

task automatic check_packet(input string name, input leaf_pkg::bft_packet_t expected,
                            input leaf_pkg::bft_packet_t actual);
    if (actual !== expected) begin
        $display("ERR %s expected %h actual %h", name, expected, actual);
        abort_run();
    end
endtask

task automatic check_mask(input string name, input logic [N_OUT-1:0] expected,
                          input logic [N_OUT-1:0] actual);
    if (actual !== expected) begin
        $display("ERR %s expected %h actual %h", name, expected, actual);
        abort_run();
    end
endtask

`endif

// ==== tests/leaf_node_tb.sv ====
module leaf_node_tb;

    localparam int N_IN      = leaf_pkg::NUM_IN_PORTS;
    localparam int N_OUT     = leaf_pkg::NUM_OUT_PORTS;
    localparam int WORD_BITS = leaf_pkg::PAYLOAD_BITS;

    localparam logic [leaf_pkg::LEAF_BITS-1:0] LEAF_ID = 5'd11;
    localparam int FIFO_DEPTH = 4;   // Shallow, so the FIFOs fill up

    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DELAY    = 10;
    localparam int RESET_CYCLES   = 5;
    localparam int CONFIG_CYCLES  = 12;
    localparam int TRAFFIC_CYCLES = 600;
    localparam int DRAIN_CYCLES   = 40;
    localparam int TAIL_CYCLES    = 4;
    localparam int STIM_CYCLES    = RESET_CYCLES + CONFIG_CYCLES + TRAFFIC_CYCLES +
                                    DRAIN_CYCLES + TAIL_CYCLES;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;

    logic                               clk;
    logic                               arst_n;
    logic                               resend;
    leaf_pkg::bft_packet_t              din;
    leaf_pkg::bft_packet_t              dout;
    logic [N_IN-1:0][WORD_BITS-1:0]     user_rx_data;
    logic [N_IN-1:0]                    user_rx_vld;
    logic [N_IN-1:0]                    user_rx_ack;
    logic [N_OUT-1:0][WORD_BITS-1:0]    user_tx_data;
    logic [N_OUT-1:0]                   user_tx_vld;
    logic [N_OUT-1:0]                   user_tx_ack;

    logic [31:0]      rng_state;
    int               cycle_count;
    int               resend_left;
    int               wait_grants [N_OUT];   // Grants to others while a port waits
    logic [N_OUT-1:0] tx_taken;

    leaf_node #(.LEAF_ID(LEAF_ID), .FIFO_DEPTH(FIFO_DEPTH)) DUT (
        .clk(clk), .arst_n(arst_n), .resend(resend), .din(din), .dout(dout),
        .user_rx_data(user_rx_data), .user_rx_vld(user_rx_vld), .user_rx_ack(user_rx_ack),
        .user_tx_data(user_tx_data), .user_tx_vld(user_tx_vld), .user_tx_ack(user_tx_ack)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    `include "leaf_node_checks.svh"

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout, the run went past %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'(lcg_next() >> 16) % n;   // Upper bits only
    endfunction

    function automatic int pending_total();
        int total;
        total = $countones(user_tx_vld);
        for (int i = 0; i < N_IN; i++) begin
            total += exp_rx[i].size();
        end
        for (int j = 0; j < N_OUT; j++) begin
            total += exp_tx[j].size();
        end
        return total;
    endfunction

    // Steps 0 to 5 program the routes, then one out-of-range and one foreign write
    task automatic drive_config(input int step);
        logic [WORD_BITS-1:0] word;
        word = lcg_next();
        din  = '0;
        if (step < N_OUT + 2) begin
            din.vld     = 1'b1;
            din.leaf    = LEAF_ID;
            din.addr    = leaf_pkg::ADDR_BITS'(step);
            din.payload = word;
            if (step == N_OUT) begin
                din.addr = leaf_pkg::ADDR_BITS'(N_OUT + rand_below(128 - N_OUT));
            end
            if (step == N_OUT + 1) begin
                din.leaf = LEAF_ID ^ leaf_pkg::LEAF_BITS'(1);
                din.addr = '0;
            end
            if (din.leaf == LEAF_ID) begin
                apply_config(din.addr, word);
            end
        end
    endtask

    task automatic drive_inputs(input bit traffic);
        int kind;
        int p;
        if (!traffic) begin
            resend_left = 0;
        end else if (resend_left == 0 && rand_below(24) == 0) begin
            resend_left = 1 + rand_below(8);   // Short burst
        end
        resend = (resend_left > 0);
        if (resend_left > 0) begin
            resend_left--;
        end
        for (int j = 0; j < N_OUT; j++) begin
            if (!user_tx_vld[j] || tx_taken[j]) begin
                if (traffic && rand_below(8) < 5) begin
                    user_tx_vld[j]  = 1'b1;
                    user_tx_data[j] = lcg_next();
                end else begin
                    user_tx_vld[j] = 1'b0;
                end
            end
        end
        tx_taken = '0;
        for (int i = 0; i < N_IN; i++) begin
            user_rx_ack[i] = traffic ? (rand_below(2) == 1) : 1'b1;
        end
        din = '0;
        if (traffic) begin
            kind        = rand_below(16);
            p           = 1 + rand_below(2);
            din.leaf    = LEAF_ID;
            din.port    = leaf_pkg::PORT_BITS'(p);
            din.addr    = leaf_pkg::ADDR_BITS'(lcg_next());
            din.payload = lcg_next();
            if (kind < 6) begin
                if (exp_rx[p-1].size() < FIFO_DEPTH) begin
                    din.vld = 1'b1;
                    exp_rx[p-1].push_back(din.payload);
                end
            end else if (kind < 8) begin
                din.vld  = 1'b1;
                din.leaf = LEAF_ID ^ leaf_pkg::LEAF_BITS'(1 + rand_below(31));
            end else if (kind < 10) begin
                din.vld  = 1'b1;
                din.port = leaf_pkg::PORT_BITS'(3 + rand_below(13));   // No such port
            end else if (kind == 10) begin
                din.vld  = 1'b1;
                din.leaf = LEAF_ID ^ leaf_pkg::LEAF_BITS'(1 + rand_below(31));
                din.port = '0;
            end
        end
    endtask

    task automatic check_outputs();
        for (int i = 0; i < N_IN; i++) begin
            if (user_rx_vld[i] && exp_rx[i].size() == 0) begin
                $display("User in-port %0d shows a word that was never sent to it", i);
                abort_run();
            end else if (user_rx_vld[i] && user_rx_ack[i]) begin
                check_word($sformatf("user_rx_data[%0d]", i), exp_rx[i].pop_front(),
                           user_rx_data[i]);
            end
        end
        if ($countones(user_tx_ack) > 1) begin
            $display("More than one user out-port was acknowledged in one cycle");
            abort_run();
        end
        if (resend) begin
            check_mask("user_tx_ack", '0, user_tx_ack);
        end
        for (int j = 0; j < N_OUT; j++) begin
            if (user_tx_ack[j] && !user_tx_vld[j]) begin
                $display("User out-port %0d was acknowledged without a word", j);
                abort_run();
            end else if (user_tx_ack[j]) begin
                exp_tx[j].push_back(expected_packet(j, user_tx_data[j]));
                tx_taken[j]    = 1'b1;
                wait_grants[j] = 0;
            end else if (user_tx_vld[j] && |user_tx_ack) begin
                wait_grants[j]++;
                if (wait_grants[j] >= N_OUT) begin
                    $display("User out-port %0d was passed over %0d times", j, wait_grants[j]);
                    abort_run();
                end
            end else if (!user_tx_vld[j]) begin
                wait_grants[j] = 0;
            end
        end
        if (resend || !dout.vld) begin
            check_packet("dout", '0, dout);
        end else if (int'(dout.addr) >= N_OUT) begin
            $display("A packet left with source port %0d, which does not exist", dout.addr);
            abort_run();
        end else if (exp_tx[dout.addr].size() == 0) begin
            $display("A packet left for out-port %0d with no word waiting", dout.addr);
            abort_run();
        end else begin
            check_packet("dout", exp_tx[dout.addr].pop_front(), dout);
        end
    endtask

    task automatic run_cycle(input bit traffic);
        @(posedge clk);
        #DRIVE_DELAY;
        drive_inputs(traffic);
        @(negedge clk);
        check_outputs();
    endtask

    initial begin
        arst_n       = 1'b0;
        resend       = 1'b0;
        din          = '0;
        user_rx_ack  = '0;
        user_tx_data = '0;
        user_tx_vld  = '0;
        rng_state    = 32'h3a6a;
        cycle_count  = 0;
        resend_left  = 0;
        tx_taken     = '0;
        for (int j = 0; j < N_OUT; j++) begin
            route_model[j] = '0;
            wait_grants[j] = 0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        @(negedge clk);
        check_packet("dout", '0, dout);
        check_mask("user_rx_vld", '0, N_OUT'(user_rx_vld));
        check_mask("user_tx_ack", '0, user_tx_ack);

        for (int n = 0; n < CONFIG_CYCLES; n++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            drive_config(n);
            @(negedge clk);
            check_outputs();
        end

        for (int n = 0; n < TRAFFIC_CYCLES; n++) begin
            run_cycle(1'b1);
        end

        // Ack everything, no new words, resend low
        for (int n = 0; n < DRAIN_CYCLES && pending_total() != 0; n++) begin
            run_cycle(1'b0);
        end
        repeat (TAIL_CYCLES) run_cycle(1'b0);

        if (pending_total() != 0) begin
            $display("%0d words were still undelivered after the drain", pending_total());
            abort_run();
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

// ==== design/leaf_node.sv ====
module leaf_node #(
    parameter logic [leaf_pkg::LEAF_BITS-1:0] LEAF_ID    = 5,
    parameter int                             FIFO_DEPTH = 8
) (
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                resend,
    input  leaf_pkg::bft_packet_t               din,
    output leaf_pkg::bft_packet_t               dout,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0][leaf_pkg::PAYLOAD_BITS-1:0] user_rx_data,
    output logic [leaf_pkg::NUM_IN_PORTS-1:0]   user_rx_vld,
    input  logic [leaf_pkg::NUM_IN_PORTS-1:0]   user_rx_ack,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0][leaf_pkg::PAYLOAD_BITS-1:0] user_tx_data,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]  user_tx_vld,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]  user_tx_ack
);

    leaf_pkg::rx_item_t                rx_item;
    logic [leaf_pkg::NUM_IN_PORTS-1:0] fifo_push;
    logic                              grant_vld;
    logic [leaf_pkg::OUT_IDX_BITS-1:0] grant_idx;
    logic [leaf_pkg::PAYLOAD_BITS-1:0] grant_payload;
    leaf_pkg::route_entry_t            route;

    leaf_rx_decode #(.LEAF_ID(LEAF_ID)) u_rx_decode (
        .clk(clk), .arst_n(arst_n), .din(din), .rx_item(rx_item)
    );

    // User in-port i takes data packets for network port i+1
    for (genvar i = 0; i < leaf_pkg::NUM_IN_PORTS; i++) begin : g_in
        assign fifo_push[i] = (rx_item.kind == leaf_pkg::PKT_DATA) &&
                              (rx_item.port == leaf_pkg::PORT_BITS'(i + 1));

        leaf_in_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_in_fifo (
            .clk(clk), .arst_n(arst_n),
            .push(fifo_push[i]), .push_data(rx_item.payload),
            .data(user_rx_data[i]), .vld(user_rx_vld[i]), .ack(user_rx_ack[i])
        );
    end

    leaf_route_table u_route_table (
        .clk(clk), .arst_n(arst_n), .rx_item(rx_item),
        .rd_idx(grant_idx), .rd_entry(route)
    );

    leaf_tx_arbiter u_tx_arbiter (
        .clk(clk), .arst_n(arst_n), .resend(resend),
        .req(user_tx_vld), .req_data(user_tx_data), .ack(user_tx_ack),
        .grant_vld(grant_vld), .grant_idx(grant_idx), .grant_payload(grant_payload)
    );

    leaf_tx_packer u_tx_packer (
        .clk(clk), .arst_n(arst_n), .resend(resend),
        .grant_vld(grant_vld), .grant_idx(grant_idx), .grant_payload(grant_payload),
        .route(route), .dout(dout)
    );

endmodule

// ==== design/leaf_tx_packer.sv ====
module leaf_tx_packer (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              resend,
    input  logic                              grant_vld,
    input  logic [leaf_pkg::OUT_IDX_BITS-1:0] grant_idx,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0] grant_payload,
    input  leaf_pkg::route_entry_t            route,
    output leaf_pkg::bft_packet_t             dout
);

    leaf_pkg::bft_packet_t pkt_d;
    leaf_pkg::bft_packet_t pkt_q;

    always_comb begin
        pkt_d.vld     = 1'b1;
        pkt_d.leaf    = route.leaf;
        pkt_d.port    = route.port;
        pkt_d.addr    = leaf_pkg::ADDR_BITS'(grant_idx); // Source port index
        pkt_d.payload = grant_payload;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_q <= '0;
        end else if (!resend) begin
            if (grant_vld) begin
                pkt_q <= pkt_d;
            end else begin
                pkt_q <= '0; // Idle cycles go out as zeros
            end
        end
        // Held while resend is high, sent once it drops
    end

    assign dout = resend ? '0 : pkt_q;

endmodule

// ==== design/leaf_tx_arbiter.sv ====
module leaf_tx_arbiter (
    input  logic                                  clk,
    input  logic                                  arst_n,
    input  logic                                  resend,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0]    req,
    input  logic [leaf_pkg::NUM_OUT_PORTS-1:0][leaf_pkg::PAYLOAD_BITS-1:0] req_data,
    output logic [leaf_pkg::NUM_OUT_PORTS-1:0]    ack,
    output logic                                  grant_vld,
    output logic [leaf_pkg::OUT_IDX_BITS-1:0]     grant_idx,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0]     grant_payload
);

    logic [leaf_pkg::OUT_IDX_BITS-1:0] last_q;
    logic [leaf_pkg::OUT_IDX_BITS-1:0] sel;
    logic                              found;
    logic                              grant;

    // First requester after the last winner, wrapping at six
    always_comb begin : pick
        int cand;
        found = 1'b0;
        sel   = last_q;
        for (int k = 1; k <= leaf_pkg::NUM_OUT_PORTS; k++) begin
            cand = (int'(last_q) + k) % leaf_pkg::NUM_OUT_PORTS;
            if (!found && req[cand]) begin
                found = 1'b1;
                sel   = leaf_pkg::OUT_IDX_BITS'(cand);
            end
        end
    end

    assign grant = found && !resend;
    assign ack   = grant ? (leaf_pkg::NUM_OUT_PORTS'(1) << sel) : '0;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            last_q    <= leaf_pkg::OUT_IDX_BITS'(leaf_pkg::NUM_OUT_PORTS - 1); // Port 0 first
            grant_vld <= 1'b0;
            grant_idx <= '0;
        end else if (!resend) begin
            grant_vld <= grant;
            if (grant) begin
                last_q    <= sel;
                grant_idx <= sel;
            end
        end
        // Under resend the grant stays put until the packer takes it
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            grant_payload <= req_data[sel];
        end
    end

endmodule

// ==== design/leaf_route_table.sv ====
module leaf_route_table (
    input  logic                              clk,
    input  logic                              arst_n,
    input  leaf_pkg::rx_item_t                rx_item,
    input  logic [leaf_pkg::OUT_IDX_BITS-1:0] rd_idx,
    output leaf_pkg::route_entry_t            rd_entry
);

    leaf_pkg::route_entry_t route_q [leaf_pkg::NUM_OUT_PORTS];
    logic                   wr_en;
    logic [leaf_pkg::OUT_IDX_BITS-1:0] wr_idx;

    // Config addr picks the output port, out-of-range addresses do nothing
    assign wr_en  = (rx_item.kind == leaf_pkg::PKT_CONFIG) &&
                    (rx_item.addr < leaf_pkg::ADDR_BITS'(leaf_pkg::NUM_OUT_PORTS));
    assign wr_idx = rx_item.addr[leaf_pkg::OUT_IDX_BITS-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < leaf_pkg::NUM_OUT_PORTS; i++) begin
                route_q[i] <= '0;
            end
        end else if (wr_en) begin
            // Payload[8:4] is the leaf, [3:0] the port
            route_q[wr_idx].leaf <= rx_item.payload[leaf_pkg::PORT_BITS +: leaf_pkg::LEAF_BITS];
            route_q[wr_idx].port <= rx_item.payload[0 +: leaf_pkg::PORT_BITS];
        end
    end

    always_comb begin
        if (rd_idx < leaf_pkg::OUT_IDX_BITS'(leaf_pkg::NUM_OUT_PORTS)) begin
            rd_entry = route_q[rd_idx];
        end else begin
            rd_entry = '0;
        end
    end

endmodule

// ==== design/leaf_in_fifo.sv ====
module leaf_in_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              push,
    input  logic [leaf_pkg::PAYLOAD_BITS-1:0] push_data,
    output logic [leaf_pkg::PAYLOAD_BITS-1:0] data,
    output logic                              vld,
    input  logic                              ack
);

    localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

    logic [leaf_pkg::PAYLOAD_BITS-1:0] mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0]               wr_ptr;
    logic [PTR_BITS-1:0]               rd_ptr;
    logic [CNT_BITS-1:0]               count;
    logic                              full;
    logic                              pop;
    logic                              wr_en;

    assign vld   = (count != '0);
    assign full  = (count == CNT_BITS'(FIFO_DEPTH));
    assign pop   = ack && vld;          // Ack on an empty FIFO is ignored
    assign wr_en = push && (!full || pop);
    assign data  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // Both or neither
            endcase
        end
    end

endmodule

// ==== design/leaf_rx_decode.sv ====
module leaf_rx_decode #(
    parameter logic [leaf_pkg::LEAF_BITS-1:0] LEAF_ID = 5
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  leaf_pkg::bft_packet_t din,
    output leaf_pkg::rx_item_t    rx_item
);

    leaf_pkg::pkt_kind_e                kind_d;
    leaf_pkg::pkt_kind_e                kind_q;
    logic [leaf_pkg::PORT_BITS-1:0]     port_q;
    logic [leaf_pkg::ADDR_BITS-1:0]     addr_q;
    logic [leaf_pkg::PAYLOAD_BITS-1:0]  payload_q;
    logic                               leaf_match;

    assign leaf_match = (din.leaf == LEAF_ID);

    // Classify the packet as it arrives
    always_comb begin
        if (!din.vld) begin
            kind_d = leaf_pkg::PKT_NONE;
        end else if (!leaf_match) begin
            kind_d = leaf_pkg::PKT_FOREIGN; // Meant for another leaf
        end else if (din.port == '0) begin
            kind_d = leaf_pkg::PKT_CONFIG;  // Port 0 is the route table
        end else begin
            kind_d = leaf_pkg::PKT_DATA;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            kind_q <= leaf_pkg::PKT_NONE;
        end else begin
            kind_q <= kind_d;
        end
    end

    // Fields only matter when kind says so
    always_ff @(posedge clk) begin
        port_q    <= din.port;
        addr_q    <= din.addr;
        payload_q <= din.payload;
    end

    assign rx_item = '{
        kind:    kind_q,
        port:    port_q,
        addr:    addr_q,
        payload: payload_q
    };

endmodule

// ==== design/leaf_pkg.sv ====
package leaf_pkg;

    // Packet field widths
    localparam int LEAF_BITS    = 5;
    localparam int PORT_BITS    = 4;
    localparam int ADDR_BITS    = 7;
    localparam int PAYLOAD_BITS = 32;
    localparam int PACKET_BITS  = 1 + LEAF_BITS + PORT_BITS + ADDR_BITS + PAYLOAD_BITS;

    localparam int NUM_IN_PORTS  = 2;
    localparam int NUM_OUT_PORTS = 6;
    localparam int OUT_IDX_BITS  = $clog2(NUM_OUT_PORTS);

    // Network packet, vld is the top bit
    typedef struct packed {
        logic                    vld;
        logic [LEAF_BITS-1:0]    leaf;
        logic [PORT_BITS-1:0]    port;
        logic [ADDR_BITS-1:0]    addr;
        logic [PAYLOAD_BITS-1:0] payload;
    } bft_packet_t;

    // Where one output port sends its words
    typedef struct packed {
        logic [LEAF_BITS-1:0] leaf;
        logic [PORT_BITS-1:0] port;
    } route_entry_t;

    typedef enum logic [1:0] {
        PKT_NONE,
        PKT_CONFIG,
        PKT_DATA,
        PKT_FOREIGN
    } pkt_kind_e;

    // Decoded packet, fanned out to the FIFOs and the route table
    typedef struct packed {
        pkt_kind_e               kind;
        logic [PORT_BITS-1:0]    port;
        logic [ADDR_BITS-1:0]    addr;
        logic [PAYLOAD_BITS-1:0] payload;
    } rx_item_t;

endpackage
